// File: compile.f
hw/video_modes_pkg.sv
hw/buffer_config_pkg.sv
hw/scan_timing_if.sv
hw/scan_timing.sv
hw/frame_buffer.sv
hw/display_scanout.sv
hw/display_top.sv
sim/display_checker.sv
sim/display_tb.sv

// File: Bender.yml
package:
  name: vga_display

sources:
  - hw/video_modes_pkg.sv
  - hw/buffer_config_pkg.sv
  - hw/scan_timing_if.sv
  - hw/scan_timing.sv
  - hw/frame_buffer.sv
  - hw/display_scanout.sv
  - hw/display_top.sv
  - target: simulation
    files:
      - sim/display_checker.sv
      - sim/display_tb.sv

// File: sim/display_tb.sv
/* Testbench for the display top level in the small test mode.
   Random buffer contents are mirrored in a model and every output pixel is predicted. */
`timescale 1ns/1ps

module display_tb;

    localparam video_modes_pkg::video_mode_t MODE = video_modes_pkg::VMODE_TEST_64x48;
    localparam buffer_config_pkg::buffer_config_t BUF = buffer_config_pkg::BUFFER_16x12x12;

    localparam int H_RES = int'(MODE.h_resolution);
    localparam int V_RES = int'(MODE.v_resolution);
    localparam int LINE_W = H_RES + int'(MODE.h_front_porch) + int'(MODE.h_sync)
                          + int'(MODE.h_back_porch);
    localparam int FRAME_H = V_RES + int'(MODE.v_front_porch) + int'(MODE.v_sync)
                           + int'(MODE.v_back_porch);
    localparam int FRAME_CYCLES = LINE_W * FRAME_H;
    localparam int HS_START = H_RES + int'(MODE.h_front_porch);
    localparam int HS_END = HS_START + int'(MODE.h_sync);
    localparam int VS_START = V_RES + int'(MODE.v_front_porch);
    localparam int VS_END = VS_START + int'(MODE.v_sync);
    localparam logic H_IDLE = !MODE.h_sync_pol;
    localparam logic V_IDLE = !MODE.v_sync_pol;
    localparam int BUF_W = int'(BUF.width);
    localparam int DEPTH = BUF_W * int'(BUF.height);
    // Screen pixels per buffer pixel in each direction
    localparam int FACTOR = H_RES / BUF_W;
    localparam int TIMEOUT = 2 * FRAME_CYCLES;

    logic clk_pixel;
    logic rstn_pixel;
    logic wr_en;
    logic [buffer_config_pkg::MAX_ADDR_WIDTH-1:0] wr_addr;
    buffer_config_pkg::color_t wr_data;
    logic vga_hsync;
    logic vga_vsync;
    logic [3:0] vga_red;
    logic [3:0] vga_green;
    logic [3:0] vga_blue;
    logic frame_start;

    buffer_config_pkg::color_t model [DEPTH];
    string test_name;
    // Raster position the pins should show, once locked to frame_start
    int mx;
    int my;
    bit synced;
    bit pixel_check;
    bit saw_frame_start;
    int since_frame_start;
    int frames_checked;

    display_top #(
        .VIDEO_MODE    (MODE),
        .BUFFER_CONFIG (BUF)
    ) dut_i (
        .clk_pixel (clk_pixel), .rstn_pixel (rstn_pixel),
        .wr_en (wr_en), .wr_addr (wr_addr), .wr_data (wr_data),
        .vga_hsync (vga_hsync), .vga_vsync (vga_vsync),
        .vga_red (vga_red), .vga_green (vga_green), .vga_blue (vga_blue),
        .frame_start (frame_start)
    );

    bind display_top display_checker #(.VIDEO_MODE(VIDEO_MODE)) checker_i (
        .clk_pixel (clk_pixel), .rstn_pixel (rstn_pixel), .vga_hsync (vga_hsync),
        .vga_red (vga_red), .vga_green (vga_green), .vga_blue (vga_blue),
        .frame_start (frame_start)
    );

    initial clk_pixel = 1'b0;
    always #2 clk_pixel = ~clk_pixel;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch in %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("error: %s", reason);
        $display("=== FAIL ===");
        $fatal(1, "run aborted");
    endtask

    // Waits for the next falling edge and checks the pins against the model
    task automatic check_cycle();
        buffer_config_pkg::color_t pix;
        logic exp_hs;
        logic exp_vs;
        @(negedge clk_pixel);
        if (dut_i.checker_i.failures != 0) begin
            abort_run("an output assertion in the checker failed");
        end
        saw_frame_start = 1'b0;
        // No frame can start while reset is held
        if ((frame_start === 1'b1) && rstn_pixel) begin
            if (synced) begin
                check_value({test_name, " frame cadence"}, FRAME_CYCLES, since_frame_start);
                frames_checked++;
            end
            mx = 0;
            my = 0;
            synced = 1'b1;
            since_frame_start = 0;
            saw_frame_start = 1'b1;
        end
        since_frame_start++;
        if (!synced) begin
            check_value({test_name, " hsync"}, H_IDLE, vga_hsync);
            check_value({test_name, " vsync"}, V_IDLE, vga_vsync);
            check_value({test_name, " colors"}, 0, {vga_blue, vga_green, vga_red});
            check_value({test_name, " frame_start"}, 0, frame_start);
        end else begin
            exp_hs = ((mx >= HS_START) && (mx < HS_END)) ? MODE.h_sync_pol : H_IDLE;
            exp_vs = ((my >= VS_START) && (my < VS_END)) ? MODE.v_sync_pol : V_IDLE;
            check_value({test_name, " hsync"}, exp_hs, vga_hsync);
            check_value({test_name, " vsync"}, exp_vs, vga_vsync);
            check_value({test_name, " frame_start"}, (mx == 0) && (my == 0), frame_start);
            if (!((mx < H_RES) && (my < V_RES))) begin
                check_value({test_name, " blanking"}, 0, {vga_blue, vga_green, vga_red});
            end else if (pixel_check) begin
                pix = model[(my / FACTOR) * BUF_W + mx / FACTOR];
                check_value({test_name, " pixel"}, {pix.blue, pix.green, pix.red},
                            {vga_blue, vga_green, vga_red});
            end
            mx++;
            if (mx == LINE_W) begin
                mx = 0;
                my = (my == FRAME_H - 1) ? 0 : my + 1;
            end
        end
    endtask

    task automatic host_write(input int addr, input buffer_config_pkg::color_t data);
        wr_en = 1'b1;
        wr_addr = 16'(addr);
        wr_data = data;
        // Writes past the buffer end are dropped by the DUT
        if (addr < DEPTH) begin
            model[addr] = data;
        end
    endtask

    task automatic wait_frame_start(output int cycles);
        cycles = 0;
        do begin
            check_cycle();
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run("no frame_start within two frame lengths");
            end
        end while (!saw_frame_start);
    endtask

    task automatic fill_buffer();
        for (int a = 0; a < DEPTH; a++) begin
            check_cycle();
            host_write(a, 12'($urandom));
        end
        check_cycle();
        wr_en = 1'b0;
    endtask

    // Writes to random addresses with random gaps, back to back included
    task automatic random_writes(input int count);
        int gap;
        for (int i = 0; i < count; i++) begin
            check_cycle();
            host_write($urandom_range(255, 0), 12'($urandom));
            gap = $urandom_range(30, 0);
            for (int g = 0; g < gap; g++) begin
                check_cycle();
                wr_en = 1'b0;
            end
        end
        check_cycle();
        wr_en = 1'b0;
    endtask

    initial begin
        int cycles;
        void'($urandom(32'hacc3));
        rstn_pixel = 1'b0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        synced = 1'b0;
        pixel_check = 1'b0;
        saw_frame_start = 1'b0;
        since_frame_start = 0;
        frames_checked = 0;
        mx = 0;
        my = 0;
        test_name = "reset";
        repeat (5) check_cycle();
        rstn_pixel = 1'b1;
        // Pixel 0,0 reaches the pins two clocks after release
        wait_frame_start(cycles);
        check_value("reset latency", 2, cycles);
        test_name = "buffer fill";
        fill_buffer();
        wait_frame_start(cycles);
        test_name = "pixel mapping";
        pixel_check = 1'b1;
        wait_frame_start(cycles);
        test_name = "live update";
        pixel_check = 1'b0;
        random_writes(60);
        wait_frame_start(cycles);
        test_name = "updated frame";
        pixel_check = 1'b1;
        wait_frame_start(cycles);
        check_value("frames checked", 4, frames_checked);
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: sim/display_checker.sv
/* Assertions on the VGA pins of the display top level, attached with bind.
   Follows the output raster from frame_start to know where blanking applies. */
`timescale 1ns/1ps

module display_checker #(
    parameter video_modes_pkg::video_mode_t VIDEO_MODE = video_modes_pkg::VMODE_640x480p60
) (
    input logic clk_pixel,
    input logic rstn_pixel,
    input logic vga_hsync,
    input logic [3:0] vga_red,
    input logic [3:0] vga_green,
    input logic [3:0] vga_blue,
    input logic frame_start
);

    localparam int H_RES = int'(VIDEO_MODE.h_resolution);
    localparam int V_RES = int'(VIDEO_MODE.v_resolution);
    localparam int LINE_W = H_RES + int'(VIDEO_MODE.h_front_porch)
                          + int'(VIDEO_MODE.h_sync) + int'(VIDEO_MODE.h_back_porch);
    localparam int FRAME_H = V_RES + int'(VIDEO_MODE.v_front_porch)
                           + int'(VIDEO_MODE.v_sync) + int'(VIDEO_MODE.v_back_porch);
    localparam int H_SYNC = int'(VIDEO_MODE.h_sync);

    int failures = 0;
    int out_x;
    int out_y;
    int cur_x;
    int cur_y;
    logic counting;
    logic hs_on;

    // Position now on the pins
    assign cur_x = frame_start ? 0 : out_x;
    assign cur_y = frame_start ? 0 : out_y;
    assign hs_on = (vga_hsync == VIDEO_MODE.h_sync_pol);

    always_ff @(posedge clk_pixel or negedge rstn_pixel) begin
        if (!rstn_pixel) begin
            out_x <= 0;
            out_y <= 0;
            counting <= 1'b0;
        end else begin
            if (frame_start) begin
                counting <= 1'b1;
            end
            if (cur_x == LINE_W - 1) begin
                out_x <= 0;
                out_y <= (cur_y == FRAME_H - 1) ? 0 : cur_y + 1;
            end else begin
                out_x <= cur_x + 1;
                out_y <= cur_y;
            end
        end
    end

    blank_outside_active: assert property (@(posedge clk_pixel) disable iff (!rstn_pixel)
        ((counting || frame_start) && !((cur_x < H_RES) && (cur_y < V_RES)))
            |-> ({vga_blue, vga_green, vga_red} == 12'h000)
    ) else begin
        failures++;
        $error("color pins not blank outside the active window");
    end

    single_frame_start: assert property (@(posedge clk_pixel) disable iff (!rstn_pixel)
        frame_start |=> !frame_start
    ) else begin
        failures++;
        $error("frame_start high on two cycles in a row");
    end

    hsync_width: assert property (@(posedge clk_pixel) disable iff (!rstn_pixel)
        $rose(hs_on) |-> hs_on [*H_SYNC] ##1 !hs_on
    ) else begin
        failures++;
        $error("hsync pulse width differs from the mode");
    end

endmodule

// File: hw/display_top.sv
/* VGA display subsystem with a host-written frame buffer.
   Outputs describe the raster position from two clocks earlier. */
`timescale 1ns/1ps

module display_top #(
    parameter video_modes_pkg::video_mode_t VIDEO_MODE = video_modes_pkg::VMODE_640x480p60,
    parameter buffer_config_pkg::buffer_config_t BUFFER_CONFIG =
        buffer_config_pkg::BUFFER_160x120x12
) (
    input  logic clk_pixel,
    input  logic rstn_pixel,

    // Host write port
    input  logic wr_en,
    input  logic [buffer_config_pkg::MAX_ADDR_WIDTH-1:0] wr_addr,
    input  buffer_config_pkg::color_t wr_data,

    // VGA pins
    output logic vga_hsync,
    output logic vga_vsync,
    output logic [3:0] vga_red,
    output logic [3:0] vga_green,
    output logic [3:0] vga_blue,

    // Pulses with pixel 0,0 on the pins
    output logic frame_start
);

    scan_timing_if timing_if ();

    logic [buffer_config_pkg::MAX_ADDR_WIDTH-1:0] rd_addr;
    buffer_config_pkg::color_t rd_data;

    scan_timing #(
        .VIDEO_MODE (VIDEO_MODE)
    ) timing_i (
        .clk_pixel  (clk_pixel),
        .rstn_pixel (rstn_pixel),
        .timing     (timing_if.source)
    );

    frame_buffer #(
        .BUFFER_CONFIG (BUFFER_CONFIG)
    ) frame_buffer_i (
        .clk_pixel (clk_pixel),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    display_scanout #(
        .VIDEO_MODE    (VIDEO_MODE),
        .BUFFER_CONFIG (BUFFER_CONFIG)
    ) scanout_i (
        .clk_pixel   (clk_pixel),
        .rstn_pixel  (rstn_pixel),
        .timing      (timing_if.sink),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .vga_hsync   (vga_hsync),
        .vga_vsync   (vga_vsync),
        .vga_red     (vga_red),
        .vga_green   (vga_green),
        .vga_blue    (vga_blue),
        .frame_start (frame_start)
    );

endmodule

// File: hw/display_scanout.sv
/* Maps raster positions to buffer addresses and drives the registered VGA pins.
   Flags are delayed two clocks to line up with the color from the buffer. */
`timescale 1ns/1ps

module display_scanout #(
    parameter video_modes_pkg::video_mode_t VIDEO_MODE = video_modes_pkg::VMODE_640x480p60,
    parameter buffer_config_pkg::buffer_config_t BUFFER_CONFIG =
        buffer_config_pkg::BUFFER_160x120x12
) (
    input  logic clk_pixel,
    input  logic rstn_pixel,
    scan_timing_if.sink timing,
    output logic [buffer_config_pkg::MAX_ADDR_WIDTH-1:0] rd_addr,
    input  buffer_config_pkg::color_t rd_data,
    output logic vga_hsync,
    output logic vga_vsync,
    output logic [3:0] vga_red,
    output logic [3:0] vga_green,
    output logic [3:0] vga_blue,
    output logic frame_start
);

    localparam int AW = buffer_config_pkg::MAX_ADDR_WIDTH;
    localparam int BUF_WIDTH = int'(BUFFER_CONFIG.width);
    // Each buffer pixel covers 2**SCALE screen pixels in each direction
    localparam int SCALE = $clog2(int'(VIDEO_MODE.h_resolution) / BUF_WIDTH);
    localparam logic H_IDLE = ~VIDEO_MODE.h_sync_pol;
    localparam logic V_IDLE = ~VIDEO_MODE.v_sync_pol;

    logic [31:0] buf_x;
    logic [31:0] buf_y;

    always_comb begin
        buf_x = 32'(timing.x) >> SCALE;
        buf_y = 32'(timing.y) >> SCALE;
        rd_addr = AW'(buf_y * BUF_WIDTH + buf_x);
    end

    // First delay stage, aligned with rd_data
    logic hsync_d1;
    logic vsync_d1;
    logic active_d1;
    logic frame_start_d1;

    always_ff @(posedge clk_pixel or negedge rstn_pixel) begin
        if (!rstn_pixel) begin
            hsync_d1 <= H_IDLE;
            vsync_d1 <= V_IDLE;
            active_d1 <= 1'b0;
            frame_start_d1 <= 1'b0;
        end else begin
            hsync_d1 <= timing.hsync;
            vsync_d1 <= timing.vsync;
            active_d1 <= timing.active;
            frame_start_d1 <= timing.frame_start;
        end
    end

    // Unpack and blank outside the active area
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;

    always_comb begin
        red = active_d1 ? rd_data.red : 4'h0;
        green = active_d1 ? rd_data.green : 4'h0;
        blue = active_d1 ? rd_data.blue : 4'h0;
    end

    // Output pins, second delay stage
    always_ff @(posedge clk_pixel or negedge rstn_pixel) begin
        if (!rstn_pixel) begin
            vga_hsync <= H_IDLE;
            vga_vsync <= V_IDLE;
            vga_red <= 4'h0;
            vga_green <= 4'h0;
            vga_blue <= 4'h0;
            frame_start <= 1'b0;
        end else begin
            vga_hsync <= hsync_d1;
            vga_vsync <= vsync_d1;
            vga_red <= red;
            vga_green <= green;
            vga_blue <= blue;
            frame_start <= frame_start_d1;
        end
    end

endmodule

// File: hw/frame_buffer.sv
/* Color memory with a host write port and a registered scanout read port.
   Reads return the old word when the same address is written in that cycle. */
`timescale 1ns/1ps

module frame_buffer #(
    parameter buffer_config_pkg::buffer_config_t BUFFER_CONFIG =
        buffer_config_pkg::BUFFER_160x120x12
) (
    input  logic clk_pixel,
    input  logic wr_en,
    input  logic [buffer_config_pkg::MAX_ADDR_WIDTH-1:0] wr_addr,
    input  buffer_config_pkg::color_t wr_data,
    input  logic [buffer_config_pkg::MAX_ADDR_WIDTH-1:0] rd_addr,
    output buffer_config_pkg::color_t rd_data
);

    localparam int DEPTH = buffer_config_pkg::buffer_depth(BUFFER_CONFIG);
    localparam int AW = int'(BUFFER_CONFIG.addr_width);

    buffer_config_pkg::color_t mem [DEPTH];

    // Only the low address bits select a word
    logic [AW-1:0] wr_index;
    logic [AW-1:0] rd_index;

    assign wr_index = wr_addr[AW-1:0];
    assign rd_index = rd_addr[AW-1:0];

    // Writes past the last word are dropped
    always_ff @(posedge clk_pixel) begin
        if (wr_en && (int'(wr_index) < DEPTH)) begin
            mem[wr_index] <= wr_data;
        end
    end

    always_ff @(posedge clk_pixel) begin
        rd_data <= mem[rd_index];
    end

endmodule

// File: hw/scan_timing.sv
/* Raster generator that walks every position of a video mode, one per clock.
   Flags are computed for the next position so they register with the counters. */
`timescale 1ns/1ps

module scan_timing #(
    parameter video_modes_pkg::video_mode_t VIDEO_MODE = video_modes_pkg::VMODE_640x480p60
) (
    input logic clk_pixel,
    input logic rstn_pixel,
    scan_timing_if.source timing
);

    localparam int PW = video_modes_pkg::POS_WIDTH;
    localparam int LINE_WIDTH = video_modes_pkg::line_width(VIDEO_MODE);
    localparam int FRAME_HEIGHT = video_modes_pkg::frame_height(VIDEO_MODE);

    // Sync windows start after the active area and the front porch
    localparam int H_SYNC_START = int'(VIDEO_MODE.h_resolution) + int'(VIDEO_MODE.h_front_porch);
    localparam int H_SYNC_END = H_SYNC_START + int'(VIDEO_MODE.h_sync);
    localparam int V_SYNC_START = int'(VIDEO_MODE.v_resolution) + int'(VIDEO_MODE.v_front_porch);
    localparam int V_SYNC_END = V_SYNC_START + int'(VIDEO_MODE.v_sync);

    // Idle level of each sync line
    localparam logic H_IDLE = ~VIDEO_MODE.h_sync_pol;
    localparam logic V_IDLE = ~VIDEO_MODE.v_sync_pol;

    logic [PW-1:0] x_next;
    logic [PW-1:0] y_next;
    logic hsync_next;
    logic vsync_next;
    logic active_next;
    logic frame_start_next;

    // Next raster position, wrapping at the end of the line and frame
    always_comb begin
        x_next = timing.x + 1'b1;
        y_next = timing.y;
        if (timing.x == PW'(LINE_WIDTH - 1)) begin
            x_next = '0;
            if (timing.y == PW'(FRAME_HEIGHT - 1)) begin
                y_next = '0;
            end else begin
                y_next = timing.y + 1'b1;
            end
        end
    end

    // Inverting the window with the idle level applies the polarity
    always_comb begin
        hsync_next = ((x_next >= PW'(H_SYNC_START)) && (x_next < PW'(H_SYNC_END))) ^ H_IDLE;
        vsync_next = ((y_next >= PW'(V_SYNC_START)) && (y_next < PW'(V_SYNC_END))) ^ V_IDLE;
        active_next = (x_next < PW'(VIDEO_MODE.h_resolution))
                   && (y_next < PW'(VIDEO_MODE.v_resolution));
        frame_start_next = (x_next == '0) && (y_next == '0);
    end

    // Reset state describes position 0,0
    always_ff @(posedge clk_pixel or negedge rstn_pixel) begin
        if (!rstn_pixel) begin
            timing.x <= '0;
            timing.y <= '0;
            timing.hsync <= H_IDLE;
            timing.vsync <= V_IDLE;
            timing.active <= 1'b1;
            timing.frame_start <= 1'b1;
        end else begin
            timing.x <= x_next;
            timing.y <= y_next;
            timing.hsync <= hsync_next;
            timing.vsync <= vsync_next;
            timing.active <= active_next;
            timing.frame_start <= frame_start_next;
        end
    end

endmodule

// File: hw/scan_timing_if.sv
/* Current raster position with its sync and active flags.
   Driven by the timing generator, read by the scanout. */
`timescale 1ns/1ps

interface scan_timing_if;

    logic [video_modes_pkg::POS_WIDTH-1:0] x;
    logic [video_modes_pkg::POS_WIDTH-1:0] y;
    // Syncs are already at mode polarity
    logic hsync;
    logic vsync;
    logic active;
    // High only at position 0,0
    logic frame_start;

    modport source (
        output x, y, hsync, vsync, active, frame_start
    );

    modport sink (
        input x, y, hsync, vsync, active, frame_start
    );

endinterface

// File: hw/buffer_config_pkg.sv
/* Frame buffer geometry and the packed pixel color format.
   A configuration constant from here is passed as the BUFFER_CONFIG parameter. */
package buffer_config_pkg;

    // Width of host write addresses and of the scanout read address
    localparam int MAX_ADDR_WIDTH = 16;

    // 12-bit color, red in the low nibble
    typedef struct packed {
        logic [3:0] blue;
        logic [3:0] green;
        logic [3:0] red;
    } color_t;

    typedef struct packed {
        logic [15:0] width;
        logic [15:0] height;
        logic [15:0] addr_width;
    } buffer_config_t;

    // Quarter resolution buffer for 640x480
    localparam buffer_config_t BUFFER_160x120x12 = '{
        width: 16'd160, height: 16'd120, addr_width: 16'd15
    };

    // Quarter resolution buffer for the 64x48 test mode
    localparam buffer_config_t BUFFER_16x12x12 = '{
        width: 16'd16, height: 16'd12, addr_width: 16'd8
    };

    // Number of color words held by a buffer
    function automatic int buffer_depth(buffer_config_t cfg);
        return int'(cfg.width) * int'(cfg.height);
    endfunction

endpackage

// File: hw/video_modes_pkg.sv
/* Video mode descriptions for the raster timing and scanout blocks.
   A mode constant from here is passed as the VIDEO_MODE parameter. */
package video_modes_pkg;

    // Width of the x and y raster counters
    localparam int POS_WIDTH = 12;

    // Horizontal and vertical timing, sync polarity 1 means active high
    typedef struct packed {
        logic [15:0] h_resolution;
        logic [15:0] h_front_porch;
        logic [15:0] h_sync;
        logic [15:0] h_back_porch;
        logic [15:0] v_resolution;
        logic [15:0] v_front_porch;
        logic [15:0] v_sync;
        logic [15:0] v_back_porch;
        logic        h_sync_pol;
        logic        v_sync_pol;
    } video_mode_t;

    // Standard 640x480 at 60 Hz, both syncs negative
    localparam video_mode_t VMODE_640x480p60 = '{
        h_resolution: 16'd640, h_front_porch: 16'd16, h_sync: 16'd96, h_back_porch: 16'd48,
        v_resolution: 16'd480, v_front_porch: 16'd10, v_sync: 16'd2, v_back_porch: 16'd33,
        h_sync_pol: 1'b0, v_sync_pol: 1'b0
    };

    // Small mode for fast simulation, 80 clocks per line and 56 lines
    localparam video_mode_t VMODE_TEST_64x48 = '{
        h_resolution: 16'd64, h_front_porch: 16'd4, h_sync: 16'd8, h_back_porch: 16'd4,
        v_resolution: 16'd48, v_front_porch: 16'd2, v_sync: 16'd3, v_back_porch: 16'd3,
        h_sync_pol: 1'b1, v_sync_pol: 1'b1
    };

    // Total clocks per line, blanking included
    function automatic int line_width(video_mode_t mode);
        return int'(mode.h_resolution) + int'(mode.h_front_porch)
             + int'(mode.h_sync) + int'(mode.h_back_porch);
    endfunction

    // Total lines per frame, blanking included
    function automatic int frame_height(video_mode_t mode);
        return int'(mode.v_resolution) + int'(mode.v_front_porch)
             + int'(mode.v_sync) + int'(mode.v_back_porch);
    endfunction

endpackage
